// ==== bench/spi_cmd_tb.sv ====
`timescale 1ns/10ps

`include "spi_cmd_defs.svh"

module spi_cmd_tb;

  localparam int HALF_SCK   = 8;   // clk cycles per mclk half-period
  localparam int WAIT_LIMIT = 400; // cycles before a wait gives up
  localparam logic [7:0] PREAMBLE = 8'hA5;

  // acknowledge bytes per opcode
  localparam logic [7:0] ACK_ECHO      = 8'h22;
  localparam logic [7:0] ACK_RAM_WRITE = 8'h23;
  localparam logic [7:0] ACK_RAM_READ  = 8'h24;
  localparam logic [7:0] ACK_GPIO_DIR  = 8'h25;
  localparam logic [7:0] ACK_GPIO_DATA = 8'h26;

  logic clk;
  logic rst;
  logic mselect;
  logic mclk;
  logic mosi;
  logic miso;
  logic err;
  wire  [`GPIO_W-1:0] gpio;

  logic [`GPIO_W-1:0] drv_en;  // tb drives pin i when set
  logic [`GPIO_W-1:0] drv_val;
  logic [31:0]        lcg_state;
  logic [7:0]         ref_ram [0:255];
  logic               err_allowed; // only the bad-opcode frame may raise err

  for (genvar i = 0; i < `GPIO_W; i++) begin : g_drv
    assign gpio[i] = drv_en[i] ? drv_val[i] : 1'bz;
  end

  spi_cmd_top spi_cmd_top_i (
    .clk     (clk),
    .rst     (rst),
    .mselect (mselect),
    .mclk    (mclk),
    .mosi    (mosi),
    .miso    (miso),
    .err     (err),
    .gpio    (gpio)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "stopping after first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    assert (got === exp)
      else fail_now($sformatf("CHECK FAILED at %0t ns: %s expected %02h, got %02h",
                              $time, name, exp, got));
  endtask

  a_err_expected: assert property (@(posedge clk) disable iff (rst) err |-> err_allowed)
    else fail_now($sformatf("CHECK FAILED at %0t ns: err expected 0, got 1", $time));

  a_miso_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(miso))
    else fail_now($sformatf("CHECK FAILED at %0t ns: miso expected 0 or 1, got %b",
                            $time, miso));

  // inputs change 1 ns after the edge
  task automatic step_clk(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // mode 0, MSB first, miso taken just before the rising mclk
  task automatic shift_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
    int i;
    rx = 8'h00;
    for (i = 0; i < nbits; i++) begin
      mosi = tx[7-i];
      step_clk(HALF_SCK);
      rx[7-i] = miso;
      mclk = 1'b1;
      step_clk(HALF_SCK);
      mclk = 1'b0;
    end
  endtask

  task automatic xfer_check(input logic [7:0] tx, input logic [7:0] exp, input string name);
    logic [7:0] got;
    shift_bits(tx, 8, got);
    check_byte(name, exp, got);
  endtask

  task automatic frame_begin();
    mselect = 1'b0;
    step_clk(HALF_SCK);
  endtask

  task automatic frame_end();
    step_clk(HALF_SCK);
    mselect = 1'b1;
    step_clk(4 * HALF_SCK);
  endtask

  task automatic wait_err(input logic level);
    int n;
    n = 0;
    while (err !== level && n < WAIT_LIMIT) begin
      step_clk(1);
      n++;
    end
    if (err !== level) begin
      fail_now($sformatf("timed out waiting for err to become %0b", level));
    end
  endtask

  // wait until the DUT-driven pins settle to the expected levels
  task automatic wait_pins(input logic [`GPIO_W-1:0] mask, input logic [`GPIO_W-1:0] exp);
    int n;
    n = 0;
    while ((gpio & mask) !== (exp & mask) && n < WAIT_LIMIT) begin
      step_clk(1);
      n++;
    end
    if ((gpio & mask) !== (exp & mask)) begin
      fail_now("timed out waiting for the output pins to take the written value");
    end
  endtask

  task automatic run_echo(input int count);
    logic [7:0] exp;
    logic [7:0] d;
    int         k;
    frame_begin();
    xfer_check(PREAMBLE, `FILL_BYTE, "preamble reply");
    xfer_check(spi_cmd_pkg::op_echo, `FILL_BYTE, "opcode reply");
    exp = ACK_ECHO;
    for (k = 0; k < count; k++) begin
      d = next_rand();
      xfer_check(d, exp, "echo reply");
      exp = d; // echoed one byte later
    end
    xfer_check(8'h00, exp, "echo reply");
    frame_end();
  endtask

  task automatic run_ram(input int count);
    logic [7:0] start;
    logic [7:0] addr;
    logic [7:0] d;
    int         k;
    start = 8'hF0 | (next_rand() & 8'h0F); // close to the top, so it wraps
    frame_begin();
    xfer_check(PREAMBLE, `FILL_BYTE, "preamble reply");
    xfer_check(spi_cmd_pkg::op_ram_write, `FILL_BYTE, "opcode reply");
    xfer_check(start, ACK_RAM_WRITE, "write ack");
    for (k = 0; k < count; k++) begin
      addr = start + 8'(k);
      d = next_rand();
      ref_ram[addr] = d;
      xfer_check(d, `FILL_BYTE, "write reply");
    end
    frame_end();

    frame_begin();
    xfer_check(PREAMBLE, `FILL_BYTE, "preamble reply");
    xfer_check(spi_cmd_pkg::op_ram_read, `FILL_BYTE, "opcode reply");
    xfer_check(start, ACK_RAM_READ, "read ack");
    xfer_check(8'h00, `FILL_BYTE, "address reply");
    for (k = 0; k < count; k++) begin
      addr = start + 8'(k);
      xfer_check(8'h00, ref_ram[addr], "read data");
    end
    frame_end();
  endtask

  task automatic run_bad_opcode();
    int k;
    err_allowed = 1'b1;
    frame_begin();
    xfer_check(PREAMBLE, `FILL_BYTE, "preamble reply");
    check_byte("err", 8'h00, 8'(err));
    xfer_check(8'h3C, `FILL_BYTE, "opcode reply");
    wait_err(1'b1);
    for (k = 0; k < 4; k++) begin
      xfer_check(next_rand(), `ERR_BYTE, "error reply");
    end
    frame_end();
    wait_err(1'b0);
    err_allowed = 1'b0;
    run_echo(6);
  endtask

  task automatic run_gpio();
    logic [`GPIO_W-1:0] dir_val;
    logic [`GPIO_W-1:0] out_val;
    logic [7:0]         r;
    dir_val = 4'b1010;
    r = next_rand();
    out_val = r[`GPIO_W-1:0];
    r = next_rand();
    drv_val = r[`GPIO_W-1:0];
    drv_en  = ~dir_val; // only pins the DUT leaves as inputs

    frame_begin();
    xfer_check(PREAMBLE, `FILL_BYTE, "preamble reply");
    xfer_check(spi_cmd_pkg::op_gpio_dir, `FILL_BYTE, "opcode reply");
    xfer_check(8'(dir_val), ACK_GPIO_DIR, "dir ack");
    frame_end();
    wait_pins(dir_val, '0); // out register still at reset value

    frame_begin();
    xfer_check(PREAMBLE, `FILL_BYTE, "preamble reply");
    xfer_check(spi_cmd_pkg::op_gpio_data, `FILL_BYTE, "opcode reply");
    xfer_check(8'(out_val), ACK_GPIO_DATA, "data ack");
    // pins as seen before the first write
    xfer_check(8'(out_val), 8'(drv_val & ~dir_val), "gpio read");
    xfer_check(8'(out_val), 8'((drv_val & ~dir_val) | (out_val & dir_val)), "gpio read");
    frame_end();
    wait_pins(dir_val, out_val);
  endtask

  task automatic run_abort();
    logic [7:0] r;
    frame_begin();
    shift_bits(8'hC3, 3, r); // cut off after three bits
    frame_end();
    run_echo(4);
    check_byte("err", 8'h00, 8'(err));
  endtask

  initial begin
    rst         = 1'b1;
    mselect     = 1'b1;
    mclk        = 1'b0;
    mosi        = 1'b0;
    drv_en      = '0;
    drv_val     = '0;
    err_allowed = 1'b0;
    lcg_state   = 32'd57285;
    step_clk(10);
    rst = 1'b0;
    step_clk(5);
    check_byte("err", 8'h00, 8'(err));

    run_echo(20);
    run_ram(24);
    run_bad_opcode();
    run_gpio();
    run_abort();

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+src
src/spi_cmd_pkg.sv
src/spi_pin_sync.sv
src/spi_byte_shifter.sv
src/spi_cmd_engine.sv
src/gpio_port.sv
src/spi_cmd_top.sv
bench/spi_cmd_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module spi_cmd_tb \
  -f build.f -o spi_cmd_sim &&
./obj_dir/spi_cmd_sim | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== src/gpio_port.sv ====
`timescale 1ns/10ps

`include "spi_cmd_defs.svh"

module gpio_port (
  input  logic                    clk,
  input  logic                    rst,
  input  spi_cmd_pkg::gpio_ctrl_t ctrl,
  output logic [`GPIO_W-1:0]      gpio_in,
  inout  wire  [`GPIO_W-1:0]      gpio
);

  logic [`GPIO_W-1:0] dir_q;   // 1 = drive the pin
  logic [`GPIO_W-1:0] out_q;
  logic [`GPIO_W-1:0] in_meta;

  always_ff @(posedge clk) begin
    if (rst) begin
      dir_q <= '0; // all inputs, pins float
      out_q <= '0;
    end else begin
      if (ctrl.load_dir) begin
        dir_q <= ctrl.dir;
      end
      if (ctrl.load_out) begin
        out_q <= ctrl.out;
      end
    end
  end

  // generic tri-state per pin
  for (genvar i = 0; i < `GPIO_W; i++) begin : g_pin
    assign gpio[i] = dir_q[i] ? out_q[i] : 1'bz;
  end

  // pin reads, two stages
  always_ff @(posedge clk) begin
    in_meta <= gpio;
    gpio_in <= in_meta;
  end

endmodule

// ==== src/spi_byte_shifter.sv ====
`timescale 1ns/10ps

`include "spi_cmd_defs.svh"

module spi_byte_shifter (
  input  logic                   clk,
  input  logic                   rst,
  input  spi_cmd_pkg::spi_pins_t pins,
  input  logic                   mosi_s,
  input  logic [7:0]             reply,
  output spi_cmd_pkg::spi_byte_t rx,
  output logic                   miso
);

  logic [2:0] bit_cnt;
  logic [7:0] rx_sr;
  logic [7:0] tx_sr;
  logic       done_q;
  logic       load_q;    // tx reload strobe
  logic       skip_fall; // keep MSB through the fall after a reload

  // mode 0: sample on rise, change on fall
  always_ff @(posedge clk) begin
    if (pins.mclk_rise) begin
      rx_sr <= {rx_sr[6:0], mosi_s};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !pins.select) begin
      bit_cnt   <= 3'd0; // deselect drops a partial byte
      done_q    <= 1'b0;
      load_q    <= 1'b0;
      skip_fall <= 1'b0;
      tx_sr     <= `FILL_BYTE;
    end else begin
      done_q <= 1'b0;
      // engine reply settles one cycle after done, fetch it then
      load_q <= done_q;

      if (pins.mclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          done_q <= 1'b1; // rx_sr now holds the full byte
        end
      end

      if (load_q) begin
        tx_sr     <= reply;
        skip_fall <= 1'b1;
      end else if (pins.mclk_fall) begin
        if (skip_fall) begin
          skip_fall <= 1'b0;
        end else begin
          tx_sr <= {tx_sr[6:0], 1'b0};
        end
      end
    end
  end

  assign rx   = '{data: rx_sr, done: done_q};
  assign miso = tx_sr[7];

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done_q |=> !done_q);

endmodule

// ==== src/spi_cmd_defs.svh ====
`ifndef SPI_CMD_DEFS_SVH
`define SPI_CMD_DEFS_SVH

// scratch RAM address width, 256 bytes
`define RAM_AW 8

// number of GPIO pins
`define GPIO_W 4

// reply for a byte that has no defined answer
`define FILL_BYTE 8'h21

// every reply while in the error state
`define ERR_BYTE 8'hFF

// ack is opcode plus this
`define ACK_BASE 8'h11

`endif

// ==== src/spi_cmd_engine.sv ====
`timescale 1ns/10ps

`include "spi_cmd_defs.svh"

module spi_cmd_engine (
  input  logic                    clk,
  input  logic                    rst,
  input  spi_cmd_pkg::spi_pins_t  pins,
  input  spi_cmd_pkg::spi_byte_t  rx,
  input  logic [`GPIO_W-1:0]      gpio_in,
  output logic [7:0]              reply,
  output spi_cmd_pkg::gpio_ctrl_t gpio_ctrl,
  output logic                    err
);

  spi_cmd_pkg::cmd_state_t  state;
  spi_cmd_pkg::cmd_opcode_t opcode;

  logic [`RAM_AW-1:0] ptr;              // shared rd/wr pointer, wraps
  logic [7:0]         ram [0:(1 << `RAM_AW)-1];
  logic               ram_we;

  assign opcode = spi_cmd_pkg::cmd_opcode_t'(rx.data);

  assign ram_we = pins.select && rx.done && (state == spi_cmd_pkg::st_wr_data);

  // scratch RAM, async read
  always_ff @(posedge clk) begin
    if (ram_we) begin
      ram[ptr] <= rx.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state              <= spi_cmd_pkg::st_idle;
      reply              <= `FILL_BYTE;
      ptr                <= '0;
      err                <= 1'b0;
      gpio_ctrl.load_dir <= 1'b0;
      gpio_ctrl.load_out <= 1'b0;
    end else begin
      gpio_ctrl.load_dir <= 1'b0;
      gpio_ctrl.load_out <= 1'b0;

      if (!pins.select) begin
        // frame over, wait for the next preamble
        state <= spi_cmd_pkg::st_idle;
        reply <= `FILL_BYTE;
        ptr   <= '0;
        err   <= 1'b0;
      end else if (rx.done) begin
        case (state)
          spi_cmd_pkg::st_idle: begin
            state <= spi_cmd_pkg::st_start; // preamble ignored
          end

          spi_cmd_pkg::st_start: begin
            reply <= rx.data + `ACK_BASE;
            case (opcode)
              spi_cmd_pkg::op_echo:      state <= spi_cmd_pkg::st_echo;
              spi_cmd_pkg::op_ram_write: state <= spi_cmd_pkg::st_wr_addr;
              spi_cmd_pkg::op_ram_read:  state <= spi_cmd_pkg::st_rd_addr;
              spi_cmd_pkg::op_gpio_dir:  state <= spi_cmd_pkg::st_gpio_dir;
              spi_cmd_pkg::op_gpio_data: state <= spi_cmd_pkg::st_gpio_data;
              default: begin
                // unknown opcode, stuck until deselect
                state <= spi_cmd_pkg::st_err;
                err   <= 1'b1;
                reply <= `ERR_BYTE;
              end
            endcase
          end

          spi_cmd_pkg::st_echo: begin
            reply <= rx.data;
          end

          spi_cmd_pkg::st_wr_addr: begin
            ptr   <= rx.data[`RAM_AW-1:0];
            reply <= `FILL_BYTE;
            state <= spi_cmd_pkg::st_wr_data;
          end

          spi_cmd_pkg::st_wr_data: begin
            ptr   <= ptr + 1'b1; // byte stored by ram_we
            reply <= `FILL_BYTE;
          end

          spi_cmd_pkg::st_rd_addr: begin
            // first data comes one byte later
            ptr   <= rx.data[`RAM_AW-1:0];
            reply <= `FILL_BYTE;
            state <= spi_cmd_pkg::st_rd_data;
          end

          spi_cmd_pkg::st_rd_data: begin
            reply <= ram[ptr];
            ptr   <= ptr + 1'b1;
          end

          spi_cmd_pkg::st_gpio_dir: begin
            gpio_ctrl.dir      <= rx.data[`GPIO_W-1:0];
            gpio_ctrl.load_dir <= 1'b1;
            reply              <= `FILL_BYTE;
          end

          spi_cmd_pkg::st_gpio_data: begin
            gpio_ctrl.out      <= rx.data[`GPIO_W-1:0];
            gpio_ctrl.load_out <= 1'b1;
            reply              <= {{(8-`GPIO_W){1'b0}}, gpio_in}; // pins before this write
          end

          default: begin
            reply <= `ERR_BYTE; // st_err
          end
        endcase
      end
    end
  end

  // err is its own flop, must track the state exactly
  a_err_state: assert property (@(posedge clk) disable iff (rst)
    err == (state == spi_cmd_pkg::st_err));

  a_load_excl: assert property (@(posedge clk) disable iff (rst)
    !(gpio_ctrl.load_dir && gpio_ctrl.load_out));

endmodule

// ==== src/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  `include "spi_cmd_defs.svh"

  typedef enum logic [7:0] {
    op_echo      = 8'h11,
    op_ram_write = 8'h12,
    op_ram_read  = 8'h13,
    op_gpio_dir  = 8'h14,
    op_gpio_data = 8'h15
  } cmd_opcode_t;

  typedef enum logic [3:0] {
    st_idle,
    st_start,
    st_err,
    st_echo,
    st_wr_addr,
    st_wr_data,
    st_rd_addr,
    st_rd_data,
    st_gpio_dir,
    st_gpio_data
  } cmd_state_t;

  // synchronized SPI pins, select already active high
  typedef struct packed {
    logic select;
    logic mclk_rise;
    logic mclk_fall;
  } spi_pins_t;

  typedef struct packed {
    logic [7:0] data;
    logic       done; // one cycle per received byte
  } spi_byte_t;

  typedef struct packed {
    logic [`GPIO_W-1:0] dir; // 1 = output
    logic [`GPIO_W-1:0] out;
    logic               load_dir;
    logic               load_out;
  } gpio_ctrl_t;

endpackage

// ==== src/spi_cmd_top.sv ====
`timescale 1ns/10ps

`include "spi_cmd_defs.svh"

module spi_cmd_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              mselect, // active low
  input  logic              mclk,
  input  logic              mosi,
  output logic              miso,
  output logic              err,
  inout  wire [`GPIO_W-1:0] gpio
);

  spi_cmd_pkg::spi_pins_t  pins;
  spi_cmd_pkg::spi_byte_t  rx;
  spi_cmd_pkg::gpio_ctrl_t gpio_ctrl;

  logic                    mosi_s;
  logic [7:0]              reply;
  logic [`GPIO_W-1:0]      gpio_in;

  // input side
  spi_pin_sync spi_pin_sync_i (
    .clk     (clk),
    .rst     (rst),
    .mselect (mselect),
    .mclk    (mclk),
    .mosi    (mosi),
    .pins    (pins),
    .mosi_s  (mosi_s)
  );

  spi_byte_shifter spi_byte_shifter_i (
    .clk    (clk),
    .rst    (rst),
    .pins   (pins),
    .mosi_s (mosi_s),
    .reply  (reply),
    .rx     (rx),
    .miso   (miso)
  );

  spi_cmd_engine spi_cmd_engine_i (
    .clk       (clk),
    .rst       (rst),
    .pins      (pins),
    .rx        (rx),
    .gpio_in   (gpio_in),
    .reply     (reply),
    .gpio_ctrl (gpio_ctrl),
    .err       (err)
  );

  gpio_port gpio_port_i (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (gpio_ctrl),
    .gpio_in (gpio_in),
    .gpio    (gpio)
  );

endmodule

// ==== src/spi_pin_sync.sv ====
`timescale 1ns/10ps

module spi_pin_sync (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mselect,
  input  logic                   mclk,
  input  logic                   mosi,
  output spi_cmd_pkg::spi_pins_t pins,
  output logic                   mosi_s
);

  logic [1:0] sel_sr;    // still active low here
  logic [2:0] mclk_sr;   // third stage only for edge detect
  logic       mosi_meta;

  always_ff @(posedge clk) begin
    if (rst) begin
      sel_sr    <= 2'b11; // deselected
      mclk_sr   <= 3'b000;
      mosi_meta <= 1'b0;
      mosi_s    <= 1'b0;
    end else begin
      sel_sr    <= {sel_sr[0], mselect};
      mclk_sr   <= {mclk_sr[1:0], mclk};
      mosi_meta <= mosi;
      mosi_s    <= mosi_meta;
    end
  end

  assign pins.select    = ~sel_sr[1];
  assign pins.mclk_rise = mclk_sr[1] & ~mclk_sr[2];
  assign pins.mclk_fall = ~mclk_sr[1] & mclk_sr[2];

  // edge strobes must be exclusive or the shifter double-steps
  a_edge_excl: assert property (@(posedge clk) disable iff (rst)
    !(pins.mclk_rise && pins.mclk_fall));

endmodule
